/* Makefile */
# Verilator flow for the PLL model, timing support required
VERILATOR  := verilator
TOP        := pll_model_tb
RTL_TOP    := pll_model
FILELIST   := pll_model.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal --Mdir $(BUILD_DIR)
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* freq_gen.sv */
// one output clock from timed delays; needs Verilator --timing, period rounds to whole ps
`timescale 1ns/1ps
`include "pll_consts.svh"

module freq_gen import pll_pkg::*; (
	input  logic        clk,
	input  logic        RST,                   // sync, active high
	input  logic        PWRDWN,                // output low at once
	input  logic        period_stable,         // ref period can be trusted
	input  period_t     ref_period_1000,       // ps
	input  period_t     M_1000,                // feedback mult x1000
	input  logic [31:0] D,                     // input divider
	input  period_t     O_1000,                // output divider x1000
	output logic        Q_out,
	output period_t     out_period_length_1000 // ps
);

	gen_state_t state;
	real        calc_r;      // unrounded output period, ps
	period_t    calc_period; // ref * D * O / M
	real        half_ns;     // toggle interval
	real        poll_ns;     // how often the toggle loop rechecks state
	real        next_t;      // absolute time of next toggle, ns
	real        step;
	logic       q_tog;       // raw toggling level

	// x1000 of O and M cancel, ref already in ps
	always_comb begin
		if (M_1000 == '0)
			calc_r = 0.0; // no valid ratio
		else
			calc_r = real'(ref_period_1000) * real'(D) * real'(O_1000) / real'(M_1000);
		calc_period = calc_r;
		half_ns     = real'(out_period_length_1000) / 2000.0;
		poll_ns     = real'(ref_period_1000) / 2000.0 + 0.001; // never zero
	end

	// posedge period_stable lands in the same step as the meter's edge
	// so arm is reached there and run starts on the following clk edge
	always @(posedge clk or posedge PWRDWN or posedge period_stable) begin
		if (PWRDWN) begin
			state                  <= gen_off;
			out_period_length_1000 <= `PLL_PERIOD_RST;
		end else if (RST) begin
			state                  <= gen_idle;
			out_period_length_1000 <= `PLL_PERIOD_RST;
		end else begin
			case (state)
			gen_off:  state <= gen_idle; // power-down released
			gen_idle: if (period_stable) state <= gen_arm;
			gen_arm: begin
				if (!period_stable) begin
					state <= gen_idle;
				end else if (calc_period != '0) begin
					state                  <= gen_run; // aligned to this clk edge
					out_period_length_1000 <= calc_period;
				end
			end
			gen_run: begin
				if (!period_stable) begin
					state                  <= gen_idle;
					out_period_length_1000 <= `PLL_PERIOD_RST;
				end else if (calc_period != out_period_length_1000) begin
					state <= gen_arm; // settings changed, realign
				end
			end
			default: state <= gen_idle;
			endcase
		end
	end

	// sleeps in slices under one ref period, so a left run state is seen
	// before arm can return to run; toggle times are absolute, no drift
	always begin
		wait (state == gen_run);
		q_tog  = 1'b1; // first high on the clk edge
		next_t = $realtime + real'(out_period_length_1000) / 2000.0; // word set with run
		while (state == gen_run) begin
			step = next_t - $realtime;
			if (step > poll_ns)
				step = poll_ns;
			#(step);
			if ($realtime >= next_t - 0.0005) begin // half-ps rounding slack
				q_tog  = ~q_tog;
				next_t = next_t + half_ns;
			end
		end
		q_tog = 1'b0;
	end

	assign Q_out = q_tog & (state == gen_run); // low at once outside run

endmodule

/* lock_detector.sv */
// single lock flag for the whole model; locked never leads period_stable
`timescale 1ns/1ps
`include "pll_consts.svh"

module lock_detector (
	input  logic clk,
	input  logic RST,           // sync, active high
	input  logic PWRDWN,        // clears at once
	input  logic period_stable, // from period_meter
	output logic locked
);

	logic [`PLL_CNT_W-1:0] lock_cnt; // edges seen with stable high
	logic                  lock_q;   // delay elapsed

	// count ref edges while stable holds
	// any loss of stability restarts the wait
	always_ff @(posedge clk or posedge PWRDWN) begin
		if (PWRDWN || RST || !period_stable) begin
			lock_cnt <= '0;
			lock_q   <= 1'b0;
		end else begin
			if (lock_cnt < `PLL_LOCK_DELAY)
				lock_cnt <= lock_cnt + 1'b1; // hold at the delay
			if (lock_cnt + 1 >= `PLL_LOCK_DELAY)
				lock_q <= 1'b1;
		end
	end

	// stable falls on an edge, locked must fall on that same edge
	// registered lock_q would lag by one, so gate with the live flag
	assign locked = lock_q & period_stable;

endmodule

/* period_meter.sv */
// measures clk period from sim time in ps; simulation only, jitter beyond PLL_TOL_PS drops stable
`timescale 1ns/1ps
`include "pll_consts.svh"

module period_meter import pll_pkg::*; (
	input  logic    clk,
	input  logic    RST,             // sync, active high
	input  logic    PWRDWN,          // acts at once
	output period_t ref_period_1000, // last reading, ps
	output logic    period_stable
);

	real                   last_t;    // time of previous rising edge, ns
	logic                  have_t;    // last_t holds a real edge
	logic [`PLL_CNT_W-1:0] match_cnt; // run of agreeing readings

	// first edge after reset only stamps time
	// each later edge yields one reading
	always_ff @(posedge clk or posedge PWRDWN) begin
		real     rd_r;
		period_t rd;
		period_t diff;
		rd_r = ($realtime - last_t) * 1000.0; // ns -> ps
		rd   = rd_r;                          // rounds to whole ps
		diff = (rd > ref_period_1000) ? rd - ref_period_1000 : ref_period_1000 - rd;
		if (PWRDWN || RST) begin
			last_t          <= 0.0;
			have_t          <= 1'b0;
			match_cnt       <= '0;
			ref_period_1000 <= `PLL_PERIOD_RST;
			period_stable   <= 1'b0;
		end else begin
			last_t <= $realtime;
			have_t <= 1'b1;
			if (have_t) begin
				ref_period_1000 <= rd;
				// first reading has nothing to compare with
				if (match_cnt != '0 && diff <= `PLL_TOL_PS) begin
					if (match_cnt < `PLL_STABLE_CYCLES)
						match_cnt <= match_cnt + 1'b1; // saturate at the limit
					if (match_cnt + 1 >= `PLL_STABLE_CYCLES)
						period_stable <= 1'b1;
				end else begin
					// new run starts with this reading
					match_cnt     <= `PLL_CNT_W'(1);
					period_stable <= 1'b0;
				end
			end
		end
	end

endmodule

/* pll_checker.sv */
// watches pll_model ports, needs period_stable by hierarchy; table values must divide exactly
`timescale 1ns/1ps
`include "pll_consts.svh"

module pll_checker import pll_pkg::*; (
	input  logic                       clk,
	input  logic                       RST,
	input  logic                       PWRDWN,
	input  logic                       period_stable, // internal meter flag
	input  period_t                    M_1000,
	input  logic [31:0]                D,
	input  period_t [`PLL_NUM_OUT-1:0] O_1000,
	input  logic [`PLL_NUM_OUT-1:0]    clk_out,
	input  period_t [`PLL_NUM_OUT-1:0] out_period_length_1000,
	input  logic                       locked,
	input  logic                       check_en,  // row settled, compare now
	input  int                         ref_ps,    // ref period from the table
	input  string                      test_name,
	output logic                       meas_done, // enough output periods seen
	output int                         value_errs,
	output int                         clock_errs,
	output int                         state_errs
);

	period_t                 exp_period [`PLL_NUM_OUT]; // ratio rule result, ps
	real                     last_clk_t = 0.0;          // latest ref rise, ns
	logic                    rst_q = 1'b0;              // RST on the previous edge
	int                      clk_err_n [`PLL_NUM_OUT];
	logic [`PLL_NUM_OUT-1:0] done_bits;

	// ref * D * O / M, the x1000 of O and M cancel
	always_comb begin
		longint prod;
		for (int i = 0; i < `PLL_NUM_OUT; i++) begin
			prod = longint'(ref_ps) * longint'(D) * longint'(O_1000[i]);
			exp_period[i] = (M_1000 == '0) ? '0 : period_t'(prod / longint'(M_1000));
		end
	end

	always @(posedge clk) begin
		last_clk_t = $realtime; // before any output rise of this step
	end

	// reported period, once per settled row
	always @(posedge check_en) begin
		for (int i = 0; i < `PLL_NUM_OUT; i++) begin
			if (out_period_length_1000[i] !== exp_period[i]) begin
				value_errs++;
				$display("Error %s out%0d period: expected %0d ps, actual %0d ps",
					test_name, i, exp_period[i], out_period_length_1000[i]);
			end
		end
	end

	// reset acts one edge late, power-down at once
	always @(posedge clk) begin
		if ((rst_q || PWRDWN) && (clk_out != '0 || locked || period_stable ||
				out_period_length_1000 != '0)) begin
			state_errs++;
			$display("Error %s reset/power-down: expected all low, actual clk_out=%b locked=%b",
				test_name, clk_out, locked);
			$display("  stable=%b periods=%h", period_stable, out_period_length_1000);
		end
		rst_q = RST;
	end

	for (genvar i = 0; i < `PLL_NUM_OUT; i++) begin : g_out
		logic started   = 1'b0; // first rise since stable already checked
		logic have_rise = 1'b0;
		real  last_rise = 0.0;
		int   n_meas    = 0;
		int   align_n   = 0;
		int   freq_n    = 0;

		// first rise after stable sits on a ref edge
		always @(posedge clk_out[i] or negedge period_stable) begin
			if (!period_stable) begin
				started = 1'b0;
			end else if (!started) begin
				started = 1'b1;
				if ($realtime - last_clk_t > 0.001 || last_clk_t - $realtime > 0.001) begin
					align_n++;
					$display("Error %s out%0d first rise: expected %0.3f ns, actual %0.3f ns",
						test_name, i, last_clk_t, $realtime);
				end
			end
		end

		// rise to rise period while the row is settled
		always @(posedge clk_out[i] or negedge check_en) begin
			real meas_ns;
			real exp_ns;
			if (!check_en) begin
				have_rise = 1'b0;
				n_meas    = 0;
			end else begin
				if (have_rise) begin
					meas_ns = $realtime - last_rise;
					exp_ns  = real'(exp_period[i]) / 1000.0; // ps -> ns
					if ((meas_ns - exp_ns) * 1000.0 > `PLL_TOL_PS ||
							(exp_ns - meas_ns) * 1000.0 > `PLL_TOL_PS) begin
						freq_n++;
						$display("Error %s out%0d clock period: expected %0.3f ns, actual %0.3f ns",
							test_name, i, exp_ns, meas_ns);
					end
					n_meas++;
				end
				have_rise = 1'b1;
				last_rise = $realtime;
			end
		end

		assign clk_err_n[i] = align_n + freq_n;
		assign done_bits[i] = (n_meas >= 2); // two full periods per output
	end

	always_comb begin
		clock_errs = 0;
		for (int i = 0; i < `PLL_NUM_OUT; i++)
			clock_errs += clk_err_n[i];
	end

	assign meas_done = &done_bits;

endmodule

/* pll_consts.svh */
// shared PLL model constants; changing PLL_NUM_OUT needs matching O_1000 stimulus
`ifndef PLL_CONSTS_SVH
`define PLL_CONSTS_SVH

// number of output clocks, one freq_gen each
`define PLL_NUM_OUT 2

// matching period readings needed before period_stable
`define PLL_STABLE_CYCLES 4

// match window between successive readings, in ps
`define PLL_TOL_PS 10

// ref edges from period_stable to locked
`define PLL_LOCK_DELAY 2

// cleared value of every period word
`define PLL_PERIOD_RST 32'd0

// width of the small edge counters
// must hold PLL_STABLE_CYCLES and PLL_LOCK_DELAY
`define PLL_CNT_W 8

`endif

/* pll_model.f */
+incdir+.
pll_pkg.sv
period_meter.sv
lock_detector.sv
freq_gen.sv
pll_model.sv
pll_checker.sv
pll_model_tb.sv

/* pll_model.sv */
// behavioral PLL top; simulation only with Verilator --timing, no phase shift or duty control
`timescale 1ns/1ps
`include "pll_consts.svh"

module pll_model import pll_pkg::*; (
	input  logic                         clk,       // reference clock
	input  logic                         RST,       // sync, active high
	input  logic                         PWRDWN,    // all outputs low
	input  period_t                      M_1000,    // shared multiplier x1000
	input  logic [31:0]                  D,         // shared divider
	input  period_t [`PLL_NUM_OUT-1:0]   O_1000,    // per-output divider x1000
	output logic [`PLL_NUM_OUT-1:0]      clk_out,
	output period_t [`PLL_NUM_OUT-1:0]   out_period_length_1000, // ps
	output logic                         locked
);

	period_t ref_period_1000; // measured ref period, ps
	logic    period_stable;

	// reference measurement
	period_meter u_period_meter (
		.clk             (clk),
		.RST             (RST),
		.PWRDWN          (PWRDWN),
		.ref_period_1000 (ref_period_1000),
		.period_stable   (period_stable)
	);

	// one lock flag for all outputs
	lock_detector u_lock_detector (
		.clk           (clk),
		.RST           (RST),
		.PWRDWN        (PWRDWN),
		.period_stable (period_stable),
		.locked        (locked)
	);

	// output clocks, each with its own O divider
	for (genvar i = 0; i < `PLL_NUM_OUT; i++) begin : g_out
		freq_gen u_freq_gen (
			.clk                    (clk),
			.RST                    (RST),
			.PWRDWN                 (PWRDWN),
			.period_stable          (period_stable),
			.ref_period_1000        (ref_period_1000),
			.M_1000                 (M_1000),
			.D                      (D),
			.O_1000                 (O_1000[i]),
			.Q_out                  (clk_out[i]),
			.out_period_length_1000 (out_period_length_1000[i])
		);
	end

endmodule

/* pll_model_tb.sv */
// pll_model testbench; the table fills O_1000 for exactly two outputs, needs Verilator --timing
`timescale 1ns/1ps
`include "pll_consts.svh"

module pll_model_tb import pll_pkg::*; ();

	localparam int n_rows     = 6;
	localparam int rst_cycles = 8;
	localparam int timeout_cycles =
		2 * (n_rows * (`PLL_STABLE_CYCLES + `PLL_LOCK_DELAY + 8) + rst_cycles);
	localparam int act_rst = 0; // pulse RST with the new settings
	localparam int act_pd  = 1; // power-down, then release
	localparam int act_per = 2; // new ref period, lock has to drop by itself

	logic                       clk;
	logic                       RST;
	logic                       PWRDWN;
	period_t                    M_1000;
	logic [31:0]                D;
	period_t [`PLL_NUM_OUT-1:0] O_1000;
	logic [`PLL_NUM_OUT-1:0]    clk_out;
	period_t [`PLL_NUM_OUT-1:0] out_period_length_1000;
	logic                       locked;

	real   half_ns  = 2.0;  // ref half period, 4 ns clock
	int    ref_ps   = 4000;
	logic  check_en = 1'b0;
	string cur_name = "init";
	string waiting  = "reset";
	logic  meas_done;
	int    value_errs;
	int    clock_errs;
	int    state_errs;
	int    cycles = 0;

	// stimulus table columns
	string       row_name [n_rows];
	int          row_act  [n_rows];
	int          row_ps   [n_rows];
	period_t     row_m    [n_rows];
	logic [31:0] row_d    [n_rows];
	period_t     row_o    [n_rows][`PLL_NUM_OUT];

	initial begin
		clk = 1'b0;
		forever begin
			#(half_ns);
			clk = ~clk;
		end
	end

	pll_model u_pll_model (
		.clk                    (clk),
		.RST                    (RST),
		.PWRDWN                 (PWRDWN),
		.M_1000                 (M_1000),
		.D                      (D),
		.O_1000                 (O_1000),
		.clk_out                (clk_out),
		.out_period_length_1000 (out_period_length_1000),
		.locked                 (locked)
	);

	pll_checker u_pll_checker (
		.clk                    (clk),
		.RST                    (RST),
		.PWRDWN                 (PWRDWN),
		.period_stable          (u_pll_model.period_stable),
		.M_1000                 (M_1000),
		.D                      (D),
		.O_1000                 (O_1000),
		.clk_out                (clk_out),
		.out_period_length_1000 (out_period_length_1000),
		.locked                 (locked),
		.check_en               (check_en),
		.ref_ps                 (ref_ps),
		.test_name              (cur_name),
		.meas_done              (meas_done),
		.value_errs             (value_errs),
		.clock_errs             (clock_errs),
		.state_errs             (state_errs)
	);

	task automatic set_row(input int r, input string name, input int act, input int ps,
			input period_t m, input logic [31:0] d, input period_t o0, input period_t o1);
		row_name[r] = name;
		row_act[r]  = act;
		row_ps[r]   = ps;
		row_m[r]    = m;
		row_d[r]    = d;
		row_o[r][0] = o0;
		row_o[r][1] = o1;
	endtask

	// name, action, ref ps, M x1000, D, O0 x1000, O1 x1000
	task automatic load_table();
		set_row(0, "reset_base", act_rst, 4000, 1000, 1, 2000, 1000);
		set_row(1, "mult_x2",    act_rst, 4000, 2000, 1, 1000, 2000);
		set_row(2, "power_down", act_pd,  4000, 3000, 1, 1500, 3000);
		set_row(3, "slow_ref",   act_per, 6000, 1000, 1, 1000, 2000); // lock must drop
		set_row(4, "div_by_2",   act_rst, 6000, 2000, 2, 1000, 1500);
		set_row(5, "fast_ref",   act_per, 5000, 1000, 1, 1000, 1500);
	endtask

	// new settings on a falling edge, then wait for lock and measurements
	task automatic apply_row(input int r);
		@(negedge clk);
		check_en = 1'b0;
		cur_name = row_name[r];
		M_1000   = row_m[r];
		D        = row_d[r];
		for (int i = 0; i < `PLL_NUM_OUT; i++)
			O_1000[i] = row_o[r][i];
		ref_ps  = row_ps[r];
		half_ns = real'(row_ps[r]) / 2000.0; // takes effect from the next half
		case (row_act[r])
		act_rst: begin
			RST = 1'b1;
			repeat (2) @(negedge clk);
			RST = 1'b0;
		end
		act_pd: begin
			PWRDWN = 1'b1;
			repeat (3) @(negedge clk);
			PWRDWN = 1'b0;
		end
		default: begin
			waiting = "locked to drop";
			while (locked) @(negedge clk);
		end
		endcase
		waiting = "locked to rise";
		while (!locked) @(negedge clk);
		check_en = 1'b1;
		waiting  = "output clock measurements";
		while (!meas_done) @(negedge clk);
	endtask

	task automatic report_counts();
		$display("errors: value %0d, clock %0d, state %0d", value_errs, clock_errs, state_errs);
	endtask

	// run limit from the table length
	initial begin
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d clk cycles: test %s still waiting for %s",
			cycles, cur_name, waiting);
		report_counts();
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		RST    = 1'b1;
		PWRDWN = 1'b0;
		M_1000 = 32'd1000;
		D      = 32'd1;
		for (int i = 0; i < `PLL_NUM_OUT; i++)
			O_1000[i] = 32'd1000;
		load_table();
		repeat (rst_cycles) @(negedge clk);
		RST = 1'b0;
		for (int r = 0; r < n_rows; r++)
			apply_row(r);
		@(negedge clk);
		check_en = 1'b0;
		report_counts();
		if (value_errs + clock_errs + state_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* pll_pkg.sv */
// types for the PLL model only; no functions, scaling rules are set by the users of period_t
package pll_pkg;

	// period in ps (ns x 1000), or a ratio x1000
	// one word for ref period, output period, M and O
	typedef logic [31:0] period_t;

	// output generator FSM
	//   gen_idle  waiting for a stable reference
	//   gen_arm   stable seen, next clk edge starts the output
	//   gen_run   output toggling by timed delays
	//   gen_off   power-down, output held low
	typedef enum logic [1:0] {
		gen_idle = 2'd0,
		gen_arm  = 2'd1,
		gen_run  = 2'd2,
		gen_off  = 2'd3
	} gen_state_t;

endpackage
